// File: hdl/conv_cfg_pkg.sv
// Convolution datapath types
package conv_cfg_pkg;

	// Pixels and weights are Q2.14
	localparam int PIX_W     = 16;
	localparam int FRAC_W    = 14;
	localparam int KEPT_W    = 15;
	localparam int GUARD_W   = 2;
	localparam int ACC_W     = 32;
	localparam int MAX_LANES = 8;

	typedef logic signed [PIX_W-1:0] pix_t;

	// Accumulator bit slicing used by requantization
	typedef struct packed {
		logic               sign;
		logic [GUARD_W-1:0] guard;
		logic [KEPT_W-1:0]  kept;
		logic [FRAC_W-1:0]  frac;
	} acc_fields_t;

	typedef union packed {
		logic signed [ACC_W-1:0] raw;
		acc_fields_t             fields;
	} acc_u;

	// One tap moving down the pipeline
	typedef struct packed {
		logic valid;
		pix_t pixel;
		logic first;
		logic last;
		logic layer;
	} tap_t;

	// One output pixel with unused lanes at zero
	typedef struct packed {
		logic                       valid;
		pix_t [MAX_LANES-1:0] lane;
	} ofm_t;

endpackage

// File: hdl/ctrl_pkg.sv
// APB control definitions
package ctrl_pkg;

	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_AW-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// Register map
	localparam logic [APB_AW-1:0] REG_CTRL   = 8'h00;
	localparam logic [APB_AW-1:0] REG_STATUS = 8'h04;
	localparam logic [APB_AW-1:0] REG_PIXCNT = 8'h08;

	// Bit positions
	localparam int CTRL_START_BIT = 0;
	localparam int CTRL_LAYER_BIT = 1;
	localparam int STAT_BUSY_BIT  = 0;
	localparam int STAT_DONE_BIT  = 1;

endpackage

// File: hdl/apb_ctrl_regs.sv
// APB control and status registers
module apb_ctrl_regs #(
	parameter int OUT_PIXELS = 6
) (
	input  logic               clk,
	input  logic               rst_gen,
	input  ctrl_pkg::apb_req_t apb_req_i,
	output ctrl_pkg::apb_rsp_t apb_rsp_o,
	input  logic               window_done_i,
	input  logic               layer_end_i,
	output logic               start_o,
	output logic               layer_o,
	output logic               busy_o
);
	import ctrl_pkg::*;

	localparam int CNT_W = $clog2(OUT_PIXELS + 1);

	logic             access;
	logic             wr;
	logic             addr_hit;
	logic             start_req;
	logic             busy_q;
	logic             done_q;
	logic             layer_q;
	logic             layer_end_q;
	logic [CNT_W-1:0] pix_cnt;

	// Access phase decode
	assign access    = apb_req_i.psel && apb_req_i.penable;
	assign wr        = access && apb_req_i.pwrite;
	assign addr_hit  = apb_req_i.paddr inside {REG_CTRL, REG_STATUS, REG_PIXCNT};
	assign start_req = wr && (apb_req_i.paddr == REG_CTRL) &&
		apb_req_i.pwdata[CTRL_START_BIT];
	assign start_o   = start_req && !busy_q;

	assign apb_rsp_o.pready  = 1'b1;
	assign apb_rsp_o.pslverr = access && (!addr_hit || (start_req && busy_q));

	always_comb begin
		apb_rsp_o.prdata = '0;
		case (apb_req_i.paddr)
			REG_CTRL:   apb_rsp_o.prdata[CTRL_LAYER_BIT] = layer_q;
			REG_STATUS: begin
				apb_rsp_o.prdata[STAT_BUSY_BIT] = busy_q;
				apb_rsp_o.prdata[STAT_DONE_BIT] = done_q;
			end
			REG_PIXCNT: apb_rsp_o.prdata = APB_DW'(pix_cnt);
			default:    apb_rsp_o.prdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			busy_q      <= 1'b0;
			done_q      <= 1'b0;
			layer_q     <= 1'b0;
			layer_end_q <= 1'b0;
			pix_cnt     <= '0;
		end else begin
			layer_end_q <= layer_end_i;
			// Layer select is frozen while a layer runs
			if (wr && (apb_req_i.paddr == REG_CTRL) && !busy_q)
				layer_q <= apb_req_i.pwdata[CTRL_LAYER_BIT];
			if (start_o)
				busy_q <= 1'b1;
			else if (layer_end_i)
				busy_q <= 1'b0;
			if (start_o)
				pix_cnt <= '0;
			else if (window_done_i)
				pix_cnt <= pix_cnt + 1'b1;
			// Done lags busy by one cycle and clears on W1C
			if (start_o)
				done_q <= 1'b0;
			else if (layer_end_q)
				done_q <= 1'b1;
			else if (wr && (apb_req_i.paddr == REG_STATUS) &&
				apb_req_i.pwdata[STAT_DONE_BIT])
				done_q <= 1'b0;
		end
	end

	assign layer_o = layer_q;
	assign busy_o  = busy_q;

	a_end_count: assert property (@(posedge clk) disable iff (rst_gen)
		layer_end_i |-> (pix_cnt == CNT_W'(OUT_PIXELS - 1)));
	a_window_busy: assert property (@(posedge clk) disable iff (rst_gen)
		window_done_i |-> busy_q);

endmodule

// File: hdl/tap_sequencer.sv
// Tap and window sequencer
module tap_sequencer #(
	parameter int KERNEL_TAPS = 18,
	parameter int OUT_PIXELS  = 6
) (
	input  logic                             clk,
	input  logic                             rst_gen,
	input  logic                             start_i,
	input  logic                             layer_i,
	input  logic                             busy_i,
	input  logic                             ifm_valid_i,
	input  conv_cfg_pkg::pix_t               ifm_data_i,
	output conv_cfg_pkg::tap_t               tap_o,
	output logic [$clog2(KERNEL_TAPS+1)-1:0] waddr_o,
	output logic                             window_done_o,
	output logic                             layer_end_o
);
	localparam int TAP_W = $clog2(KERNEL_TAPS + 1);
	localparam int WIN_W = $clog2(OUT_PIXELS + 1);

	logic [TAP_W-1:0] tap_cnt;
	logic [WIN_W-1:0] win_cnt;
	logic             accept;
	logic             first_tap;
	logic             last_tap;

	// Taps only count while a layer is running
	assign accept    = ifm_valid_i && busy_i;
	assign first_tap = (tap_cnt == '0);
	assign last_tap  = (tap_cnt == TAP_W'(KERNEL_TAPS - 1));

	always_ff @(posedge clk) begin
		if (rst_gen || start_i) begin
			tap_cnt <= '0;
			win_cnt <= '0;
		end else if (accept) begin
			if (last_tap) begin
				tap_cnt <= '0;
				win_cnt <= win_cnt + 1'b1;
			end else begin
				tap_cnt <= tap_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////
	// Tap stream to weight fetch
	////////////////////////////////
	assign tap_o.valid = accept;
	assign tap_o.pixel = ifm_data_i;
	assign tap_o.first = first_tap;
	assign tap_o.last  = last_tap;
	assign tap_o.layer = layer_i;

	// Weight ROM address is simply the tap index
	assign waddr_o = tap_cnt;

	assign window_done_o = accept && last_tap;
	assign layer_end_o   = window_done_o && (win_cnt == WIN_W'(OUT_PIXELS - 1));

	a_layer_end: assert property (@(posedge clk) disable iff (rst_gen)
		layer_end_o |=> !busy_i);

endmodule

// File: hdl/weight_bank.sv
// Weight and bias tables
module weight_bank #(
	parameter int LANES       = 4,
	parameter int KERNEL_TAPS = 18
) (
	input  logic                               clk,
	input  logic                               rst_gen,
	input  conv_cfg_pkg::tap_t                 tap_i,
	input  logic [$clog2(KERNEL_TAPS+1)-1:0]   waddr_i,
	output conv_cfg_pkg::tap_t                 tap_o,
	output conv_cfg_pkg::pix_t [LANES-1:0]     weights_o,
	output conv_cfg_pkg::acc_u [LANES-1:0]     bias_o
);
	import conv_cfg_pkg::*;

	localparam int W_SHIFT = 12;
	localparam int B_SHIFT = 26;

	pix_t w_rom [2][KERNEL_TAPS][LANES];
	acc_u b_rom [2][LANES];

	// Table contents follow a fixed formula
	function automatic pix_t weight_rule(input int layer, input int tap, input int lane);
		return pix_t'(((tap * 3 + lane * 5 + layer * 7) % 16 - 8) * (1 << W_SHIFT));
	endfunction

	for (genvar ly = 0; ly < 2; ly++) begin : g_layer
		for (genvar l = 0; l < LANES; l++) begin : g_lane
			assign b_rom[ly][l].raw = ACC_W'((l - 2 + ly) * (1 << B_SHIFT));
			for (genvar t = 0; t < KERNEL_TAPS; t++) begin : g_tap
				assign w_rom[ly][t][l] = weight_rule(ly, t, l);
			end
		end
	end

	////////////////////////////////
	// Layer mux and fetch register
	////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen)
			tap_o <= '0;
		else
			tap_o <= tap_i;
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < LANES; l++) begin
			weights_o[l] <= w_rom[tap_i.layer][waddr_i][l];
			bias_o[l]    <= b_rom[tap_i.layer][l];
		end
	end

endmodule

// File: hdl/mac_array.sv
// Per-lane multiply accumulate
module mac_array #(
	parameter int LANES = 4
) (
	input  logic                           clk,
	input  logic                           rst_gen,
	input  conv_cfg_pkg::tap_t             tap_i,
	input  conv_cfg_pkg::pix_t [LANES-1:0] weights_i,
	input  conv_cfg_pkg::acc_u [LANES-1:0] bias_i,
	output conv_cfg_pkg::acc_u [LANES-1:0] acc_o,
	output conv_cfg_pkg::acc_u [LANES-1:0] bias_o,
	output logic                           last_o
);
	import conv_cfg_pkg::*;

	acc_u [LANES-1:0]        acc_q;
	logic signed [ACC_W-1:0] prod [LANES];
	logic                    in_win;

	always_comb begin
		for (int l = 0; l < LANES; l++)
			prod[l] = $signed(tap_i.pixel) * $signed(weights_i[l]);
	end

	// First tap restarts the sum with its own product
	always_ff @(posedge clk) begin
		for (int l = 0; l < LANES; l++) begin
			if (tap_i.valid) begin
				if (tap_i.first)
					acc_q[l].raw <= prod[l];
				else
					acc_q[l].raw <= acc_q[l].raw + prod[l];
			end
		end
		if (tap_i.valid && tap_i.last)
			bias_o <= bias_i;
	end

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			last_o <= 1'b0;
			in_win <= 1'b0;
		end else begin
			last_o <= tap_i.valid && tap_i.last;
			if (tap_i.valid)
				in_win <= !tap_i.last;
		end
	end

	assign acc_o = acc_q;

	a_first_order: assert property (@(posedge clk) disable iff (rst_gen)
		tap_i.valid && tap_i.first |-> !in_win);
	a_last_order: assert property (@(posedge clk) disable iff (rst_gen)
		tap_i.valid && tap_i.last |-> (in_win || tap_i.first));

endmodule

// File: hdl/bias_relu_stage.sv
// Bias, ReLU and requantization
module bias_relu_stage #(
	parameter int LANES = 4
) (
	input  logic                           clk,
	input  logic                           rst_gen,
	input  conv_cfg_pkg::acc_u [LANES-1:0] acc_i,
	input  conv_cfg_pkg::acc_u [LANES-1:0] bias_i,
	input  logic                           last_i,
	output conv_cfg_pkg::ofm_t             ofm_o
);
	import conv_cfg_pkg::*;

	acc_u [LANES-1:0] sum;
	pix_t [LANES-1:0] res_q;
	logic             valid_q;

	always_comb begin
		for (int l = 0; l < LANES; l++)
			sum[l].raw = acc_i[l].raw + bias_i[l].raw;
	end

	////////////////////////////////
	// ReLU then keep bits 31, 28:14
	////////////////////////////////
	always_ff @(posedge clk) begin
		if (last_i) begin
			for (int l = 0; l < LANES; l++) begin
				if ($signed(sum[l].raw) < 0)
					res_q[l] <= '0;
				else
					res_q[l] <= {sum[l].fields.sign, sum[l].fields.kept};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_gen)
			valid_q <= 1'b0;
		else
			valid_q <= last_i;
	end

	assign ofm_o.valid = valid_q;

	// Lanes beyond LANES read as zero
	for (genvar l = 0; l < MAX_LANES; l++) begin : g_out
		if (l < LANES) begin : g_used
			assign ofm_o.lane[l] = res_q[l];
		end else begin : g_unused
			assign ofm_o.lane[l] = '0;
		end
	end

endmodule

// File: hdl/conv_expand_top.sv
// Expand convolution engine top
module conv_expand_top #(
	parameter int LANES       = 4,
	parameter int KERNEL_TAPS = 18,
	parameter int OUT_PIXELS  = 6
) (
	input  logic               clk,
	input  logic               rst_gen,
	input  ctrl_pkg::apb_req_t apb_req_i,
	output ctrl_pkg::apb_rsp_t apb_rsp_o,
	input  logic               ifm_valid_i,
	input  conv_cfg_pkg::pix_t ifm_data_i,
	output conv_cfg_pkg::ofm_t ofm_o
);
	import conv_cfg_pkg::*;

	localparam int TAP_W = $clog2(KERNEL_TAPS + 1);

	if (LANES > MAX_LANES) begin : g_lane_check
		$error("LANES exceeds MAX_LANES");
	end

	logic             start;
	logic             layer;
	logic             busy;
	logic             window_done;
	logic             layer_end;
	logic [TAP_W-1:0] waddr;
	tap_t             seq_tap;
	tap_t             wb_tap;
	pix_t [LANES-1:0] weights;
	acc_u [LANES-1:0] wb_bias;
	acc_u [LANES-1:0] mac_acc;
	acc_u [LANES-1:0] mac_bias;
	logic             mac_last;

	apb_ctrl_regs #(.OUT_PIXELS(OUT_PIXELS)) u_regs (
		.clk(clk), .rst_gen(rst_gen),
		.apb_req_i(apb_req_i), .apb_rsp_o(apb_rsp_o),
		.window_done_i(window_done), .layer_end_i(layer_end),
		.start_o(start), .layer_o(layer), .busy_o(busy)
	);

	////////////////////////////////
	// Datapath with three register stages
	////////////////////////////////
	tap_sequencer #(.KERNEL_TAPS(KERNEL_TAPS), .OUT_PIXELS(OUT_PIXELS)) u_seq (
		.clk(clk), .rst_gen(rst_gen),
		.start_i(start), .layer_i(layer), .busy_i(busy),
		.ifm_valid_i(ifm_valid_i), .ifm_data_i(ifm_data_i),
		.tap_o(seq_tap), .waddr_o(waddr),
		.window_done_o(window_done), .layer_end_o(layer_end)
	);

	weight_bank #(.LANES(LANES), .KERNEL_TAPS(KERNEL_TAPS)) u_wbank (
		.clk(clk), .rst_gen(rst_gen),
		.tap_i(seq_tap), .waddr_i(waddr),
		.tap_o(wb_tap), .weights_o(weights), .bias_o(wb_bias)
	);

	mac_array #(.LANES(LANES)) u_mac (
		.clk(clk), .rst_gen(rst_gen),
		.tap_i(wb_tap), .weights_i(weights), .bias_i(wb_bias),
		.acc_o(mac_acc), .bias_o(mac_bias), .last_o(mac_last)
	);

	bias_relu_stage #(.LANES(LANES)) u_relu (
		.clk(clk), .rst_gen(rst_gen),
		.acc_i(mac_acc), .bias_i(mac_bias), .last_i(mac_last),
		.ofm_o(ofm_o)
	);

endmodule

// File: verif/conv_expand_tb.sv
// Expand convolution testbench
module conv_expand_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import conv_cfg_pkg::*;
	import ctrl_pkg::*;

	localparam int LANES       = 4;
	localparam int KERNEL_TAPS = 18;
	localparam int OUT_PIXELS  = 6;
	localparam int PERIOD      = 40;
	// Taps of all runs (gap run up to 4 cycles per tap), idle taps, APB and drain cycles
	localparam int SEQ_CYCLES  = 7 * OUT_PIXELS * KERNEL_TAPS + 2 * KERNEL_TAPS +
		2 * (20 + OUT_PIXELS) + 40;
	localparam int WATCHDOG_NS = SEQ_CYCLES * PERIOD * 2;

	logic     clk = 1'b0;
	logic     rst_gen;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     ifm_valid;
	pix_t     ifm_data;
	ofm_t     ofm;
	integer   seed = 32'h9791;
	int       cyc = 0;
	int       win_px [KERNEL_TAPS];
	int       exp_cyc_q [$];
	ofm_t     exp_ofm_q [$];

	conv_expand_top #(
		.LANES(LANES), .KERNEL_TAPS(KERNEL_TAPS), .OUT_PIXELS(OUT_PIXELS)
	) u_dut (
		.clk(clk), .rst_gen(rst_gen),
		.apb_req_i(apb_req), .apb_rsp_o(apb_rsp),
		.ifm_valid_i(ifm_valid), .ifm_data_i(ifm_data),
		.ofm_o(ofm)
	);

	initial begin
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	initial begin
		#(WATCHDOG_NS);
		stop_run("Timeout, the test sequence did not finish in time");
	end

	//////////////////////////////
	// Checking and reference model
	//////////////////////////////
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check(input string name, input logic [31:0] expv, input logic [31:0] act);
		if (expv !== act)
			stop_run($sformatf("FAILED at %0d ns: %s expected 0x%0h actual 0x%0h",
				$time, name, expv, act));
	endtask

	function automatic int weight_of(input int layer, input int tap, input int lane);
		int v;
		v = (tap * 3 + lane * 5 + layer * 7) % 16;
		return (v - 8) * 4096;
	endfunction

	// Expected output pixel for the taps held in win_px
	task automatic model_window(input int layer, output ofm_t res);
		logic signed [31:0] acc;
		logic signed [31:0] sum;
		res = '0;
		res.valid = 1'b1;
		for (int l = 0; l < LANES; l++) begin
			acc = 0;
			for (int t = 0; t < KERNEL_TAPS; t++)
				acc = acc + win_px[t] * weight_of(layer, t, l);
			sum = acc + (l - 2 + layer) * 32'sd67108864;
			if (sum < 0)
				res.lane[l] = '0;
			else
				res.lane[l] = {sum[31], sum[28:14]};
		end
	endtask

	// Each output is due at a known cycle and any other valid is an error
	always @(negedge clk) begin
		if (exp_cyc_q.size() != 0 && exp_cyc_q[0] == cyc) begin
			check("ofm_o.valid", 1, ofm.valid);
			for (int l = 0; l < MAX_LANES; l++)
				check($sformatf("ofm_o.lane[%0d]", l), exp_ofm_q[0].lane[l], ofm.lane[l]);
			void'(exp_cyc_q.pop_front());
			void'(exp_ofm_q.pop_front());
		end else if (ofm.valid === 1'b1) begin
			stop_run("Output valid arrived with no window pending at that cycle");
		end
	end

	//////////////////////////////
	// Bus and stream drivers
	//////////////////////////////
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#(PERIOD / 4);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		check("pready", 1, apb_rsp.pready);
		@(negedge clk);
		apb_req = '0;
	endtask

	// A fixed_px of 0 means random pixels
	task automatic drive_window(input int layer, input int max_gap, input int fixed_px);
		ofm_t res;
		int   gap;
		for (int t = 0; t < KERNEL_TAPS; t++) begin
			win_px[t] = (fixed_px != 0) ? fixed_px : $random(seed) % 8192;
			ifm_valid = 1'b1;
			ifm_data  = pix_t'(win_px[t]);
			if (t == KERNEL_TAPS - 1) begin
				model_window(layer, res);
				exp_ofm_q.push_back(res);
				exp_cyc_q.push_back(cyc + 3);
			end
			@(negedge clk);
			ifm_valid = 1'b0;
			gap = (max_gap > 0) ? ($random(seed) & 32'h7fffffff) % (max_gap + 1) : 0;
			repeat (gap) @(negedge clk);
		end
	endtask

	task automatic wait_drained();
		while (exp_cyc_q.size() != 0)
			@(negedge clk);
		@(negedge clk);
	endtask

	task automatic run_layer(input int layer, input int max_gap, input int first_px,
		input bit try_restart);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b1, REG_CTRL, 32'(layer * 2 + 1), rdata, err);
		check("pslverr on start", 0, err);
		if (try_restart) begin
			apb_xfer(1'b1, REG_CTRL, 32'(layer * 2 + 1), rdata, err);
			check("pslverr on start while busy", 1, err);
		end
		for (int w = 0; w < OUT_PIXELS; w++) begin
			drive_window(layer, max_gap, (w == 0) ? first_px : 0);
			if (max_gap > 0) begin
				apb_xfer(1'b0, REG_PIXCNT, '0, rdata, err);
				check("PIXCNT", w + 1, rdata);
			end
		end
		wait_drained();
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic apb_access_test();
		logic [31:0] rdata;
		logic        err;
		check("ofm_o.valid after reset", 0, ofm.valid);
		apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
		check("STATUS after reset", 0, rdata);
		check("pslverr on STATUS", 0, err);
		apb_xfer(1'b0, 8'h10, '0, rdata, err);
		check("pslverr on unmapped read", 1, err);
		apb_xfer(1'b1, REG_CTRL, 32'h2, rdata, err);
		apb_xfer(1'b0, REG_CTRL, '0, rdata, err);
		check("CTRL layer bit", 32'h2, rdata);
		apb_xfer(1'b1, REG_CTRL, 32'h0, rdata, err);
	endtask

	task automatic relu_test();
		ofm_t res;
		int   zeros;
		int   positives;
		zeros = 0;
		positives = 0;
		for (int t = 0; t < KERNEL_TAPS; t++)
			win_px[t] = -4096;
		model_window(1, res);
		for (int l = 0; l < LANES; l++) begin
			if (res.lane[l] == 0)
				zeros++;
			else
				positives++;
		end
		if (zeros == 0 || positives == 0)
			stop_run("ReLU pattern does not give both zero and positive lanes");
		else
			run_layer(1, 0, -4096, 1'b0);
	endtask

	task automatic done_test();
		logic [31:0] rdata;
		logic        err;
		run_layer(0, 0, 0, 1'b1);
		apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
		check("STATUS after final window", 32'h2, rdata);
		apb_xfer(1'b1, REG_STATUS, 32'h2, rdata, err);
		apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
		check("STATUS after done clear", 0, rdata);
		// Taps while idle must be dropped
		for (int t = 0; t < 2 * KERNEL_TAPS; t++) begin
			ifm_valid = 1'b1;
			ifm_data  = pix_t'($random(seed) % 8192);
			@(negedge clk);
		end
		ifm_valid = 1'b0;
		repeat (5) @(negedge clk);
		apb_xfer(1'b0, REG_PIXCNT, '0, rdata, err);
		check("PIXCNT after idle taps", OUT_PIXELS, rdata);
	endtask

	initial begin
		rst_gen   = 1'b1;
		apb_req   = '0;
		ifm_valid = 1'b0;
		ifm_data  = '0;
		repeat (2) @(negedge clk);
		rst_gen = 1'b0;
		apb_access_test();
		run_layer(0, 0, 0, 1'b0);
		run_layer(1, 3, 0, 1'b0);
		relu_test();
		done_test();
		$display("Verification passed");
		$finish;
	end

endmodule

// File: conv_expand_top.f
hdl/conv_cfg_pkg.sv
hdl/ctrl_pkg.sv
hdl/apb_ctrl_regs.sv
hdl/tap_sequencer.sv
hdl/weight_bank.sv
hdl/mac_array.sv
hdl/bias_relu_stage.sv
hdl/conv_expand_top.sv
verif/conv_expand_tb.sv
